//--- src.f
+incdir+common
common/regbank_pkg.sv
common/cmd_pkg.sv
async_fifo/async_fifo.sv
source/cmd_arbiter.sv
source/reg_bank.sv
source/cdc_reg_bridge.sv
tests/bridge_checker.sv
tests/tb_cdc_reg_bridge.sv

//--- Makefile
# Verilator build and run of the CDC register bridge testbench
# Any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cdc_reg_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_cdc_reg_bridge.sv
// Testbench for the CDC register bridge with seeded random pushes on both ports and a read-back
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_cdc_reg_bridge;

        localparam int BURST_CYCLES = 300;
        localparam int WAIT_LIMIT   = 400;

        logic                   w_clk     = 1'b0;
        logic                   r_clk     = 1'b0;
        logic                   w_reset_n = 1'b0;
        logic                   r_reset_n = 1'b0;
        logic                   a_push    = 1'b0;
        logic                   b_push    = 1'b0;
        cmd_pkg::wr_cmd_t       a_cmd     = '0;
        cmd_pkg::mask_cmd_t     b_cmd     = '0;
        logic                   a_full;
        logic                   b_full;
        logic                   busy;
        regbank_pkg::reg_idx_t  rb_idx    = '0;
        regbank_pkg::reg_data_t rb_data;
        regbank_pkg::reg_data_t exp_data  = '0;
        logic                   cmp_en    = 1'b0;
        logic                   quiet     = 1'b1;
        int                     data_errors;
        int                     flag_errors;
        logic                   full_seen;
        int                     other_errors = 0;
        int                     a_count      = 0;
        int                     b_count      = 0;
        logic                   a_pend       = 1'b0;      // Command held for port A
        logic                   b_pend       = 1'b0;
        integer                 seed         = 32'h4449dd4d;
        regbank_pkg::reg_data_t model [`BRIDGE_REG_NUM];

        cdc_reg_bridge uut
        (
                .w_clk     (w_clk),
                .r_clk     (r_clk),
                .w_reset_n (w_reset_n),
                .r_reset_n (r_reset_n),
                .a_push    (a_push),
                .a_cmd     (a_cmd),
                .b_push    (b_push),
                .b_cmd     (b_cmd),
                .a_full    (a_full),
                .b_full    (b_full),
                .busy      (busy),
                .rb_idx    (rb_idx),
                .rb_data   (rb_data)
        );

        bridge_checker u_checker
        (
                .w_clk       (w_clk),
                .r_clk       (r_clk),
                .w_reset_n   (w_reset_n),
                .r_reset_n   (r_reset_n),
                .a_full      (a_full),
                .b_full      (b_full),
                .busy        (busy),
                .quiet       (quiet),
                .cmp_en      (cmp_en),
                .rb_idx      (rb_idx),
                .rb_data     (rb_data),
                .exp_data    (exp_data),
                .data_errors (data_errors),
                .flag_errors (flag_errors),
                .full_seen   (full_seen)
        );

        initial
        begin
                forever #10 w_clk = ~w_clk;
        end

        // Half-ns offset keeps r_clk edges off every w_clk edge
        initial
        begin
                #3.5;
                forever #23 r_clk = ~r_clk;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Stimulus and model
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        function automatic regbank_pkg::reg_data_t apply_mask(input regbank_pkg::reg_data_t old,
                                                               input cmd_pkg::mask_cmd_t cmd);
                regbank_pkg::reg_data_t res;
                res = old;
                for (int i = 0; i < `BRIDGE_DATA_W; i++)
                begin
                        if (cmd.set_mask[i])
                                res[i] = 1'b1;                  // Set wins over clear
                        else if (cmd.clr_mask[i])
                                res[i] = 1'b0;
                end
                return res;
        endfunction

        task automatic drive_cycle(input logic allow_new);
                logic [31:0] rnd;
                @(negedge w_clk);
                rnd    = $random(seed);
                a_push = 1'b0;
                b_push = 1'b0;
                if (allow_new && !a_pend && rnd[1:0] != 2'b00)
                begin
                        a_cmd.idx  = {1'b0, rnd[6:4]};          // Registers 0 to 7
                        a_cmd.data = $random(seed);
                        a_pend     = 1'b1;
                end
                if (allow_new && !b_pend && rnd[3:2] != 2'b00)
                begin
                        b_cmd.idx      = {1'b1, rnd[9:7]};      // Registers 8 to 15
                        b_cmd.set_mask = $random(seed) & $random(seed);
                        b_cmd.clr_mask = $random(seed);
                        b_pend         = 1'b1;
                end
                if (a_pend && !a_full)                          // Held while full
                begin
                        a_push           = 1'b1;
                        model[a_cmd.idx] = a_cmd.data;
                        a_pend           = 1'b0;
                        a_count++;
                end
                if (b_pend && !b_full)
                begin
                        b_push           = 1'b1;
                        model[b_cmd.idx] = apply_mask(model[b_cmd.idx], b_cmd);
                        b_pend           = 1'b0;
                        b_count++;
                end
        endtask

        task automatic sweep_registers;
                for (int i = 0; i < `BRIDGE_REG_NUM; i++)
                begin
                        @(negedge r_clk);
                        rb_idx   = regbank_pkg::reg_idx_t'(i);
                        exp_data = model[i];
                        cmp_en   = 1'b1;
                end
                @(negedge r_clk);
                cmp_en = 1'b0;
        endtask

        initial
        begin
                int n;
                for (int i = 0; i < `BRIDGE_REG_NUM; i++)
                        model[i] = '0;
                fork
                        begin
                                repeat (8) @(posedge w_clk);
                                @(negedge w_clk);
                                w_reset_n = 1'b1;
                        end
                        begin
                                repeat (8) @(posedge r_clk);
                                @(negedge r_clk);
                                r_reset_n = 1'b1;
                        end
                join
                sweep_registers();                              // All zero after reset

                @(negedge r_clk);
                quiet = 1'b0;
                repeat (BURST_CYCLES) drive_cycle(1'b1);
                n = 0;
                while ((a_pend || b_pend) && n < WAIT_LIMIT)
                begin
                        drive_cycle(1'b0);
                        n++;
                end
                @(negedge w_clk);
                a_push = 1'b0;
                b_push = 1'b0;
                if (!full_seen)
                begin
                        $display("No full flag rose during the burst");
                        other_errors++;
                end

                if (a_pend || b_pend)
                begin
                        $display("Timeout waiting for the held commands to be accepted");
                        other_errors++;
                end
                else
                begin
                        // Last push needs up to three r_clk edges to show as busy
                        repeat (5) @(negedge r_clk);
                        n = 0;
                        while (busy && n < WAIT_LIMIT)
                        begin
                                @(negedge r_clk);
                                n++;
                        end
                        if (busy)
                        begin
                                $display("Timeout waiting for busy to fall");
                                other_errors++;
                        end
                        else
                        begin
                                repeat (4) @(negedge r_clk);
                                quiet = 1'b1;
                                sweep_registers();
                                repeat (20) @(negedge r_clk);
                        end
                end

                $display("Errors: %0d data, %0d flag, %0d other; pushes: %0d A, %0d B",
                         data_errors, flag_errors, other_errors, a_count, b_count);
                if (data_errors == 0 && flag_errors == 0 && other_errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

//--- tests/bridge_checker.sv
// Testbench checker: watches the bridge flags and read-back port, counts and reports mismatches
`timescale 1ns/1ps
`include "bridge_macros.svh"

module bridge_checker
(
        input  logic                   w_clk,
        input  logic                   r_clk,
        input  logic                   w_reset_n,
        input  logic                   r_reset_n,
        input  logic                   a_full,
        input  logic                   b_full,
        input  logic                   busy,
        input  logic                   quiet,         // No pushes outstanding
        input  logic                   cmp_en,
        input  regbank_pkg::reg_idx_t  rb_idx,
        input  regbank_pkg::reg_data_t rb_data,
        input  regbank_pkg::reg_data_t exp_data,
        output int                     data_errors,
        output int                     flag_errors,
        output logic                   full_seen
);

        int   data_errs = 0;
        int   busy_errs = 0;
        int   full_errs = 0;
        logic seen_full = 1'b0;

        assign data_errors = data_errs;
        assign flag_errors = busy_errs + full_errs;
        assign full_seen   = seen_full;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // w_clk side flags
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always @(posedge w_clk)
        begin
                if (w_reset_n && (a_full || b_full))
                        seen_full <= 1'b1;                      // Back-pressure happened
                if (w_reset_n && quiet && (a_full || b_full))
                begin
                        $display("FAILED at %0t: full flag high while idle (a %b, b %b)",
                                 $time, a_full, b_full);
                        full_errs <= full_errs + 1;
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // r_clk side, busy and read-back
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always @(posedge r_clk)
        begin
                if (r_reset_n && quiet && busy)
                begin
                        $display("FAILED at %0t: busy high while idle", $time);
                        busy_errs <= busy_errs + 1;
                end
                if (r_reset_n && cmp_en && (rb_data !== exp_data))
                begin
                        $display("FAILED at %0t: register %0d read 0x%08h, expected 0x%08h",
                                 $time, rb_idx, rb_data, exp_data);
                        data_errs <= data_errs + 1;
                end
        end

endmodule

//--- source/cdc_reg_bridge.sv
// Top level of the bridge: two w_clk command ports into the r_clk register bank
`timescale 1ns/1ps
`include "bridge_macros.svh"

module cdc_reg_bridge
(
        input  logic                   w_clk,
        input  logic                   r_clk,
        input  logic                   w_reset_n,
        input  logic                   r_reset_n,
        input  logic                   a_push,
        input  cmd_pkg::wr_cmd_t       a_cmd,
        input  logic                   b_push,
        input  cmd_pkg::mask_cmd_t     b_cmd,
        output logic                   a_full,
        output logic                   b_full,
        output logic                   busy,
        input  regbank_pkg::reg_idx_t  rb_idx,
        output regbank_pkg::reg_data_t rb_data
);

        cmd_pkg::wr_cmd_t       a_head;
        cmd_pkg::mask_cmd_t     b_head;
        logic                   a_empty;
        logic                   b_empty;
        logic                   a_rd;
        logic                   b_rd;
        logic                   wr_en;
        regbank_pkg::reg_idx_t  wr_idx;
        regbank_pkg::reg_data_t wr_data;
        regbank_pkg::reg_idx_t  rmw_idx;
        regbank_pkg::reg_data_t rmw_data;

        assign busy = !a_empty || !b_empty;     // r_clk view

        async_fifo #(.PAYLOAD_T(cmd_pkg::wr_cmd_t), .DEPTH(`BRIDGE_FIFO_DEPTH),
                     .PTR_W(`BRIDGE_PTR_W)) u_a_fifo
        (
                .w_reset_n (w_reset_n),
                .r_reset_n (r_reset_n),
                .w_clk     (w_clk),
                .r_clk     (r_clk),
                .wr        (a_push),
                .wr_data   (a_cmd),
                .rd        (a_rd),
                .rd_data   (a_head),
                .empty     (a_empty),
                .full      (a_full)
        );

        async_fifo #(.PAYLOAD_T(cmd_pkg::mask_cmd_t), .DEPTH(`BRIDGE_FIFO_DEPTH),
                     .PTR_W(`BRIDGE_PTR_W)) u_b_fifo
        (
                .w_reset_n (w_reset_n),
                .r_reset_n (r_reset_n),
                .w_clk     (w_clk),
                .r_clk     (r_clk),
                .wr        (b_push),
                .wr_data   (b_cmd),
                .rd        (b_rd),
                .rd_data   (b_head),
                .empty     (b_empty),
                .full      (b_full)
        );

        cmd_arbiter u_arbiter
        (
                .r_clk     (r_clk),
                .r_reset_n (r_reset_n),
                .a_empty   (a_empty),
                .b_empty   (b_empty),
                .a_head    (a_head),
                .b_head    (b_head),
                .a_rd      (a_rd),
                .b_rd      (b_rd),
                .wr_en     (wr_en),
                .wr_idx    (wr_idx),
                .wr_data   (wr_data),
                .rmw_idx   (rmw_idx),
                .rmw_data  (rmw_data)
        );

        reg_bank u_reg_bank
        (
                .r_clk     (r_clk),
                .r_reset_n (r_reset_n),
                .wr_en     (wr_en),
                .wr_idx    (wr_idx),
                .wr_data   (wr_data),
                .rmw_idx   (rmw_idx),
                .rmw_data  (rmw_data),
                .rb_idx    (rb_idx),
                .rb_data   (rb_data)
        );

endmodule

//--- source/reg_bank.sv
// r_clk register array with one write port, an internal RMW read and an external read-back
`timescale 1ns/1ps
`include "bridge_macros.svh"

module reg_bank
(
        input  logic                   r_clk,
        input  logic                   r_reset_n,
        input  logic                   wr_en,
        input  regbank_pkg::reg_idx_t  wr_idx,
        input  regbank_pkg::reg_data_t wr_data,
        input  regbank_pkg::reg_idx_t  rmw_idx,
        output regbank_pkg::reg_data_t rmw_data,
        input  regbank_pkg::reg_idx_t  rb_idx,
        output regbank_pkg::reg_data_t rb_data
);

        regbank_pkg::reg_data_t regs [`BRIDGE_REG_NUM];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Write port
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_ff @(posedge r_clk)
        begin
                if (!r_reset_n)
                begin
                        for (int i = 0; i < `BRIDGE_REG_NUM; i++)
                                regs[i] <= '0;                   // All registers read zero
                end
                else if (wr_en)
                begin
                        regs[wr_idx] <= wr_data;
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Read ports
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign rmw_data = regs[rmw_idx];        // Arbiter mask update
        assign rb_data  = regs[rb_idx];         // External read-back

endmodule

//--- source/cmd_arbiter.sv
// Round-robin drain of both command FIFOs into the single register write port
`timescale 1ns/1ps

module cmd_arbiter
(
        input  logic                   r_clk,
        input  logic                   r_reset_n,
        input  logic                   a_empty,
        input  logic                   b_empty,
        input  cmd_pkg::wr_cmd_t       a_head,
        input  cmd_pkg::mask_cmd_t     b_head,
        output logic                   a_rd,
        output logic                   b_rd,
        output logic                   wr_en,
        output regbank_pkg::reg_idx_t  wr_idx,
        output regbank_pkg::reg_data_t wr_data,
        output regbank_pkg::reg_idx_t  rmw_idx,
        input  regbank_pkg::reg_data_t rmw_data
);

        regbank_pkg::grant_t grant;
        regbank_pkg::grant_t last_grant;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Grant
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_comb
        begin
                grant = regbank_pkg::GRANT_NONE;
                if (!a_empty && !b_empty)
                        grant = (last_grant == regbank_pkg::GRANT_A) ? regbank_pkg::GRANT_B :
                                                                       regbank_pkg::GRANT_A;
                else if (!a_empty)
                        grant = regbank_pkg::GRANT_A;
                else if (!b_empty)
                        grant = regbank_pkg::GRANT_B;
        end

        always_ff @(posedge r_clk)
        begin
                if (!r_reset_n)
                        last_grant <= regbank_pkg::GRANT_NONE;   // A wins the first tie
                else if (grant != regbank_pkg::GRANT_NONE)
                        last_grant <= grant;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Pop and register write, same edge
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign a_rd    = grant[0];
        assign b_rd    = grant[1];
        assign wr_en   = |grant;
        assign rmw_idx = b_head.idx;                    // Old value for the mask update
        assign wr_idx  = grant[1] ? b_head.idx : a_head.idx;
        assign wr_data = grant[1] ? ((rmw_data & ~b_head.clr_mask) | b_head.set_mask) :
                                    a_head.data;

        a_grant_onehot: assert property (@(posedge r_clk) disable iff (!r_reset_n)
                $onehot0(grant));

        a_pop_not_empty: assert property (@(posedge r_clk) disable iff (!r_reset_n)
                (a_rd |-> !a_empty) and (b_rd |-> !b_empty));

endmodule

//--- async_fifo/async_fifo.sv
// Gray-pointer dual-clock FIFO carrying one payload type from w_clk to r_clk for each port
`timescale 1ns/1ps

module async_fifo
#(
        parameter type PAYLOAD_T = logic [31:0],
        parameter int  DEPTH     = 8,
        parameter int  PTR_W     = 4
)
(
        input  logic     w_reset_n,
        input  logic     r_reset_n,
        input  logic     w_clk,
        input  logic     r_clk,
        input  logic     wr,
        input  PAYLOAD_T wr_data,
        input  logic     rd,
        output PAYLOAD_T rd_data,
        output logic     empty,
        output logic     full
);

        PAYLOAD_T         mem [DEPTH];

        logic             wr_go;
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] next_wr_ptr;
        logic [PTR_W-1:0] gray_wr_ptr;
        logic [PTR_W-1:0] gray_rd_ptr_sync1;
        logic [PTR_W-1:0] rd_ptr_sync;        // Read pointer seen in w_clk

        logic             rd_go;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] next_rd_ptr;
        logic [PTR_W-1:0] gray_rd_ptr;
        logic [PTR_W-1:0] gray_wr_ptr_sync1;
        logic [PTR_W-1:0] wr_ptr_sync;        // Write pointer seen in r_clk

        function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] gray);
                logic [PTR_W-1:0] bin;
                bin[PTR_W-1] = gray[PTR_W-1];
                for (int i = PTR_W-2; i >= 0; i--)
                        bin[i] = bin[i+1] ^ gray[i];
                return bin;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Write side in w_clk
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign wr_go       = wr && !full;      // Push while full is dropped
        assign next_wr_ptr = wr_ptr + PTR_W'(wr_go);

        always_ff @(posedge w_clk)
        begin
                if (wr_go)
                        mem[wr_ptr[PTR_W-2:0]] <= wr_data;
        end

        always_ff @(posedge w_clk)
        begin
                if (!w_reset_n)
                begin
                        wr_ptr            <= '0;
                        gray_wr_ptr       <= '0;
                        gray_rd_ptr_sync1 <= '0;
                        rd_ptr_sync       <= '0;
                        full              <= 1'b0;
                end
                else
                begin
                        wr_ptr            <= next_wr_ptr;
                        gray_wr_ptr       <= next_wr_ptr ^ (next_wr_ptr >> 1);
                        gray_rd_ptr_sync1 <= gray_rd_ptr;               // First sync stage
                        rd_ptr_sync       <= gray2bin(gray_rd_ptr_sync1);
                        full              <= (next_wr_ptr[PTR_W-2:0] == rd_ptr_sync[PTR_W-2:0]) &&
                                             (next_wr_ptr[PTR_W-1] != rd_ptr_sync[PTR_W-1]);
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Read side in r_clk
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign rd_go       = rd && !empty;
        assign next_rd_ptr = rd_ptr + PTR_W'(rd_go);
        assign rd_data     = mem[rd_ptr[PTR_W-2:0]];   // Show-ahead head entry

        always_ff @(posedge r_clk)
        begin
                if (!r_reset_n)
                begin
                        rd_ptr            <= '0;
                        gray_rd_ptr       <= '0;
                        gray_wr_ptr_sync1 <= '0;
                        wr_ptr_sync       <= '0;
                        empty             <= 1'b1;
                end
                else
                begin
                        rd_ptr            <= next_rd_ptr;
                        gray_rd_ptr       <= next_rd_ptr ^ (next_rd_ptr >> 1);
                        gray_wr_ptr_sync1 <= gray_wr_ptr;
                        wr_ptr_sync       <= gray2bin(gray_wr_ptr_sync1);
                        empty             <= (next_rd_ptr == wr_ptr_sync);
                end
        end

        // Write pointer stays within one depth of the synchronized read pointer
        a_no_push_when_full: assert property (@(posedge w_clk) disable iff (!w_reset_n)
                PTR_W'(wr_ptr - rd_ptr_sync) <= PTR_W'(DEPTH));

        // Read pointer never passes the synchronized write pointer
        a_no_pop_when_empty: assert property (@(posedge r_clk) disable iff (!r_reset_n)
                PTR_W'(wr_ptr_sync - rd_ptr) <= PTR_W'(DEPTH));

endmodule

//--- common/cmd_pkg.sv
// Command payloads posted in w_clk and carried to r_clk by the async FIFOs

package cmd_pkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Port A, full-word register write
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        typedef struct packed
        {
                regbank_pkg::reg_idx_t  idx;
                regbank_pkg::reg_data_t data;   // Replaces the whole register
        } wr_cmd_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Port B, read-modify-write bit update
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // A bit present in both masks ends up set
        typedef struct packed
        {
                regbank_pkg::reg_idx_t  idx;
                regbank_pkg::reg_data_t set_mask;
                regbank_pkg::reg_data_t clr_mask;
        } mask_cmd_t;

endpackage

//--- common/regbank_pkg.sv
// Register bank types shared by the arbiter, the bank and the command payloads
`include "bridge_macros.svh"

package regbank_pkg;

        localparam int REG_IDX_W = $clog2(`BRIDGE_REG_NUM);

        typedef logic [REG_IDX_W-1:0]     reg_idx_t;
        typedef logic [`BRIDGE_DATA_W-1:0] reg_data_t;

        // One-hot arbiter grant
        typedef logic [1:0] grant_t;

        localparam grant_t GRANT_NONE = 2'b00;
        localparam grant_t GRANT_A    = 2'b01;   // Port A, full-word writes
        localparam grant_t GRANT_B    = 2'b10;   // Port B, mask updates

endpackage

//--- common/bridge_macros.svh
// Bridge sizing defines, included by the packages, the RTL and the testbench
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BRIDGE_DATA_W     32    // Register and data word width
`define BRIDGE_REG_NUM    16    // Registers in the r_clk bank

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossing FIFOs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BRIDGE_FIFO_DEPTH 8     // Entries per port

// Index bits of the depth plus one wrap bit for full/empty
`define BRIDGE_PTR_W      4

`endif
